// ==== build.f ====
hdl/conv3_pkg.sv
hdl/conv_result_if.sv
hdl/act_fifo.sv
hdl/issue_ctrl.sv
hdl/channel_mac.sv
hdl/result_packer.sv
hdl/conv3_top.sv
tb/tb_conv3.sv

// ==== hdl/act_fifo.sv ====
`timescale 1ns/1ps

module act_fifo #(
	parameter int IN_DEPTH = 4
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  conv3_pkg::in_vec_t in_data,
	input  logic               pop,
	output conv3_pkg::in_vec_t head_data,
	output logic               fifo_empty,
	output logic               in_credit
);
	import conv3_pkg::*;

	localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
	localparam int CNT_W = $clog2(IN_DEPTH + 1);

	in_vec_t          mem [IN_DEPTH];              // whole vectors, one per slot
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;                       // slots currently holding a vector
	logic             full;

	// wraps explicitly so depths that are not a power of two work too
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign fifo_empty = (count == '0);
	assign full       = (count == CNT_W'(IN_DEPTH));
	assign head_data  = mem[rd_ptr];              // head is visible without a read strobe

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;               // the source only writes while it holds a credit
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid) wr_ptr <= next_ptr(wr_ptr);
			if (pop) rd_ptr <= next_ptr(rd_ptr);
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;          // both or neither leave the fill level alone
			endcase
			in_credit <= pop;                     // a freed slot goes back to the source next cycle
		end
	end

	// the source must never outrun the credits it was given
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> !full)
		else $error("act_fifo written while full");

endmodule

// ==== hdl/channel_mac.sv ====
`timescale 1ns/1ps

module channel_mac #(
	parameter int SHIFT = 8
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               issue_valid,
	input  conv3_pkg::chan_t   issue_chan,
	input  conv3_pkg::in_vec_t issue_data,
	conv_result_if.producer    res
);
	import conv3_pkg::*;

	dot_t  dot_r [N_IN];                          // one dot product per input channel
	logic  s1_valid;
	chan_t s1_chan;
	acc_t  acc_sum;
	acc_t  acc_shift;
	out_t  clip_value;
	logic  clip_flag;

	// five-tap product sum of one input channel against one filter
	function automatic dot_t tap_dot(input act_t [TAPS-1:0] a, input weight_t [TAPS-1:0] w);
		dot_t sum;
		dot_t prod;
		sum = '0;
		for (int t = 0; t < TAPS; t++) begin
			prod = a[t] * w[t];                   // signed operands widen before the multiply
			sum  = sum + prod;
		end
		return sum;
	endfunction

	// ****************************************
	// stage 1 looks up the filters and multiplies
	// ****************************************
	always_ff @(posedge clk) begin
		if (issue_valid) begin
			for (int j = 0; j < N_IN; j++) begin
				dot_r[j] <= tap_dot(issue_data[j], conv3_weights[issue_chan][j]);
			end
			s1_chan <= issue_chan;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) s1_valid <= 1'b0;
		else s1_valid <= issue_valid;
	end

	// ****************************************
	// stage 2 accumulates, scales and clips
	// ****************************************
	always_comb begin
		acc_sum = '0;
		for (int j = 0; j < N_IN; j++) begin
			acc_sum = acc_sum + dot_r[j];         // sign extends each dot product
		end
		acc_shift = acc_sum >>> SHIFT;            // arithmetic shift rounds toward minus infinity
		clip_flag = 1'b1;
		if (acc_shift > SAT_MAX) clip_value = SAT_MAX;
		else if (acc_shift < SAT_MIN) clip_value = SAT_MIN;
		else begin
			clip_value = out_t'(acc_shift);       // in range so the low byte is exact
			clip_flag  = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			res.chan  <= s1_chan;
			res.value <= clip_value;
			res.sat   <= clip_flag;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) res.valid <= 1'b0;
		else res.valid <= s1_valid;
	end

	// every issue shows up two cycles later under the same channel number
	a_no_drop: assert property (@(posedge clk) disable iff (!arst_n)
		$past(issue_valid, 2) |-> res.valid && (res.chan == $past(issue_chan, 2)))
		else $error("channel_mac lost or reordered a result");

endmodule

// ==== hdl/conv3_pkg.sv ====
package conv3_pkg;

	// ****************************************
	// layer dimensions
	// ****************************************
	localparam int N_IN  = 8;                     // input channels per vector
	localparam int N_OUT = 8;                     // output channels, one filter bank each
	localparam int TAPS  = 5;                     // window length of every filter

	// ****************************************
	// data types
	// ****************************************
	typedef logic signed [7:0]  act_t;            // one quantized activation
	typedef logic signed [7:0]  weight_t;         // one quantized filter weight
	typedef logic signed [18:0] dot_t;            // five 8x8 products never exceed 19 bits
	typedef logic signed [21:0] acc_t;            // headroom for summing eight dot products
	typedef logic signed [7:0]  out_t;            // saturated layer output
	typedef logic [2:0]         chan_t;           // output channel index 0 to 7

	// input channel j sits at [j] and tap t of that channel at [j][t]
	typedef act_t [N_IN-1:0][TAPS-1:0] in_vec_t;
	typedef out_t [N_OUT-1:0]          out_vec_t;  // output channel k at [k]
	typedef logic [N_OUT-1:0]          sat_mask_t; // bit k set when channel k clipped

	typedef enum logic {
		ST_IDLE,                                  // waiting for a vector and a result slot
		ST_RUN                                    // sweeping output channels of the head vector
	} issue_state_t;

	localparam out_t SAT_MAX = 8'sd127;           // the range is symmetric so -128 never appears
	localparam out_t SAT_MIN = -8'sd127;

	// ****************************************
	// trained filters of layer 3
	// ****************************************
	// indexed as [output channel][input channel], each entry lists tap 4 first and tap 0 last
	localparam weight_t [TAPS-1:0] conv3_weights [N_OUT][N_IN] = '{
		'{                                        // output channel 0
			'{-6, -88, -46, 22, -33},
			'{13, 65, -14, -37, -8},
			'{-27, -85, -74, -5, 40},
			'{95, 43, 27, -62, -79},
			'{59, 9, 23, 50, 4},
			'{31, 47, -10, 41, -2},
			'{-5, 36, -72, -13, -74},
			'{77, -6, 46, 54, -110}
		},
		'{                                        // output channel 1
			'{3, 24, 54, -71, 82},
			'{92, 1, 88, 102, 50},
			'{-21, 64, 83, -17, 23},
			'{-29, 87, -67, -44, 76},
			'{-61, 77, -25, 79, -43},
			'{53, -45, -67, 11, -28},
			'{-46, -55, -8, 88, -27},
			'{-26, -80, -16, 54, -33}
		},
		'{                                        // output channel 2
			'{31, -83, 44, 16, 62},
			'{-28, -26, -73, 13, -49},
			'{49, 73, 17, 93, -3},
			'{87, 41, 24, 52, 0},
			'{70, -41, 89, -49, 106},
			'{54, -41, -14, -65, -96},
			'{61, 48, 0, -20, 62},
			'{7, -16, -8, -22, 117}
		},
		'{                                        // output channel 3
			'{120, 57, -21, -3, 21},
			'{-41, 26, -28, -70, -7},
			'{-48, 5, 67, -79, -30},
			'{77, 73, -68, -90, -68},
			'{3, -53, -40, -46, -39},
			'{23, 7, -50, -82, -11},
			'{-40, 15, -46, 45, -26},
			'{2, 35, -69, -127, 56}
		},
		'{                                        // output channel 4
			'{-91, 31, -65, 37, -95},
			'{88, -69, -9, 67, 43},
			'{-31, 41, -22, -10, -38},
			'{21, -22, 63, 16, 88},
			'{79, -31, 51, 29, -86},
			'{16, -42, -48, 31, -15},
			'{-22, 89, -52, 60, -68},
			'{-60, 16, 88, 9, -25}
		},
		'{                                        // output channel 5
			'{65, 11, 45, 19, 56},
			'{-22, 40, 19, -22, 14},
			'{-60, 74, -33, 36, -74},
			'{79, 69, -64, 63, 36},
			'{15, -34, 15, -106, 49},
			'{49, 78, 59, -13, -42},
			'{-17, -58, -48, -69, -25},
			'{44, -67, 79, -69, -98}
		},
		'{                                        // output channel 6
			'{-25, -11, 6, 3, 67},
			'{-101, 74, 80, -46, 38},
			'{8, -8, -33, 36, -3},
			'{74, -57, 6, 63, 93},
			'{-77, -2, 87, 33, 11},
			'{-124, 47, -30, -77, 25},
			'{-44, -48, -77, 8, -36},
			'{-62, -60, -76, 3, -20}
		},
		'{                                        // output channel 7
			'{68, 49, -53, 2, 56},
			'{-97, -74, 28, -2, 51},
			'{29, 70, 39, 68, -48},
			'{-23, -54, 31, 14, 4},
			'{51, -91, 45, 14, -56},
			'{-64, -95, -71, 39, 83},
			'{-30, 74, -28, 51, -53},
			'{73, 67, -33, -58, 66}
		}
	};

endpackage

// ==== hdl/conv3_top.sv ====
`timescale 1ns/1ps

module conv3_top #(
	parameter int SHIFT       = 8,                // scaling of the accumulated sum
	parameter int IN_DEPTH    = 4,                // input buffer slots, also the source's credits
	parameter int OUT_CREDITS = 2                 // result slots the sink can hold
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 in_valid,
	input  conv3_pkg::in_vec_t   in_data,
	output logic                 in_credit,
	output logic                 out_valid,
	output conv3_pkg::out_vec_t  out_data,
	output conv3_pkg::sat_mask_t out_sat,
	input  logic                 out_credit
);
	import conv3_pkg::*;

	logic    fifo_empty;
	in_vec_t head_data;                           // oldest buffered vector
	logic    pop;
	logic    issue_valid;
	chan_t   issue_chan;
	in_vec_t issue_data;

	conv_result_if res_if ();                     // engine to packer, one channel per beat

	act_fifo #(
		.IN_DEPTH (IN_DEPTH)
	) u_act_fifo (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.pop        (pop),
		.head_data  (head_data),
		.fifo_empty (fifo_empty),
		.in_credit  (in_credit)
	);

	issue_ctrl #(
		.OUT_CREDITS (OUT_CREDITS)
	) u_issue_ctrl (
		.clk         (clk),
		.arst_n      (arst_n),
		.fifo_empty  (fifo_empty),
		.head_data   (head_data),
		.pop         (pop),
		.out_credit  (out_credit),
		.issue_valid (issue_valid),
		.issue_chan  (issue_chan),
		.issue_data  (issue_data)
	);

	channel_mac #(
		.SHIFT (SHIFT)
	) u_channel_mac (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue_valid (issue_valid),
		.issue_chan  (issue_chan),
		.issue_data  (issue_data),
		.res         (res_if.producer)
	);

	result_packer u_result_packer (
		.clk       (clk),
		.arst_n    (arst_n),
		.res       (res_if.consumer),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_sat   (out_sat)
	);

endmodule

// ==== hdl/conv_result_if.sv ====
`timescale 1ns/1ps

// one finished output channel per beat, in issue order
interface conv_result_if;
	import conv3_pkg::*;

	logic  valid;                                 // a result is present this cycle
	chan_t chan;                                  // output channel the value belongs to
	out_t  value;                                 // saturated channel result
	logic  sat;                                   // the value was clipped to a limit

	// no ready signal since the output credit has already reserved room
	modport producer (
		output valid, chan, value, sat
	);

	modport consumer (
		input valid, chan, value, sat
	);

endinterface

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ps

module issue_ctrl #(
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               fifo_empty,
	input  conv3_pkg::in_vec_t head_data,
	output logic               pop,
	input  logic               out_credit,
	output logic               issue_valid,
	output conv3_pkg::chan_t   issue_chan,
	output conv3_pkg::in_vec_t issue_data
);
	import conv3_pkg::*;

	localparam int    CRD_W     = $clog2(OUT_CREDITS + 1);
	localparam chan_t LAST_CHAN = chan_t'(N_OUT - 1);

	issue_state_t     state;
	chan_t            chan_cnt;                   // channel issued this cycle, zero while idle
	logic [CRD_W-1:0] credit_cnt;                 // result slots still free at the sink
	logic             start;

	// channel 0 goes out in the same cycle the vector is accepted
	assign start       = (state == ST_IDLE) && !fifo_empty && (credit_cnt != '0);
	assign issue_valid = (state == ST_RUN) || start;
	assign issue_chan  = chan_cnt;
	assign issue_data  = head_data;               // the head stays put until the last channel
	assign pop         = (state == ST_RUN) && (chan_cnt == LAST_CHAN);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			chan_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state    <= ST_RUN;
						chan_cnt <= chan_t'(1);   // channel 0 was issued on the way in
					end
				end
				ST_RUN: begin
					chan_cnt <= chan_cnt + 1'b1;  // wraps back to zero after the last channel
					if (chan_cnt == LAST_CHAN) state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credit_cnt <= CRD_W'(OUT_CREDITS);
		end else begin
			case ({start, out_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;   // one slot reserved per vector
				2'b01:   credit_cnt <= credit_cnt + 1'b1;   // the sink freed a slot
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// the sink never returns more slots than it was given
	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credit_cnt <= CRD_W'(OUT_CREDITS))
		else $error("output credit count above OUT_CREDITS");

	// a pop ends a full sweep that started seven cycles earlier on a live head
	a_pop_sweep: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> (state == ST_RUN) && (issue_chan == LAST_CHAN) && !fifo_empty
			&& $past(issue_valid, 7) && ($past(issue_chan, 7) == '0))
		else $error("pop outside a complete channel sweep");

endmodule

// ==== hdl/result_packer.sv ====
`timescale 1ns/1ps

module result_packer (
	input  logic                 clk,
	input  logic                 arst_n,
	conv_result_if.consumer      res,
	output logic                 out_valid,
	output conv3_pkg::out_vec_t  out_data,
	output conv3_pkg::sat_mask_t out_sat
);
	import conv3_pkg::*;

	localparam chan_t LAST_CHAN = chan_t'(N_OUT - 1);

	// slots are overwritten in place, channel 0 of the next vector lands one cycle
	// after out_valid so the presented vector is still whole on that cycle
	always_ff @(posedge clk) begin
		if (res.valid) begin
			out_data[res.chan] <= res.value;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= 1'b0;
			out_sat   <= '0;
		end else begin
			out_valid <= res.valid && (res.chan == LAST_CHAN);   // single beat per vector
			if (res.valid) begin
				for (int k = 0; k < N_OUT; k++) begin
					if (chan_t'(k) == res.chan) out_sat[k] <= res.sat;
					else if (res.chan == '0) out_sat[k] <= 1'b0;   // a new vector starts clean
				end
			end
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# the data file path in the testbench is relative to the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv3 -f build.f -o tb_conv3_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_conv3_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "*** PASSED ***" <<< "$sim_out"; then
	exit 0
fi
exit 1

// ==== tb/conv3_testdata.txt ====
// columns: input vector (channel 7 tap 4 first), expected outputs (channel 7 first), sat mask
// expected values use the layer-3 filters, a shift of 8 and clipping to -127..127
00000000000000000000000000000000000000000000000000000000000000000000000000000000 0000000000000000 00
01010101010101010101010101010101010101010101010101010101010101010101010101010101 00ff0000fd0201ff 00
ffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffff ff00ffff02fdfe00 00
0000000000000000000000000000000000000000000000000000000000000000000000000000007f 1b211bd00a1e28ef 00
80000000000000000000000000000000000000000000000000000000000000000000000000000000 db1fea1efffc0dd9 00
000000000000000000000000000000000000ce000000640000000000000000000000000000000000 09fbfb12ee12d600 00
0000000000000000000000000000000000000000000000000000000000007f7f7f7f7f0000000000 d1160e3bc4af7f09 02
000000000000000000000000000000000000000000000000009c9c9c9c9c00000000000000000000 c200161721a6cc3a 00
808080808000000000007f7f7f7f7f00000000000000000000000000000000000000000000000000 901c78d5fb880c16 00
02020202020202020202020202020202020202020202020202020202020202020202020202020202 01fe0000fb0402ff 00
20202020202020202020202020202020202020202020202020202020202020202020202020202020 11e00b07bb482ff6 00
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 46812e1e817f7fdb 0e
80808080808080808080808080808080808080808080808080808080808080808080808080808080 b97fd1e17f818125 0e
40404040404040404040404040404040404040404040404040404040404040404040404040404040 23c0170f817f5fed 0c
c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0c0 dc3fe8f07f81a012 0c
64646464646464646464646464646464646464646464646464646464646464646464646464646464 379c2418817f7fe3 0e
80808080807f7f7f7f7f80808080807f7f7f7f7f80808080807f7f7f7f7f80808080807f7f7f7f7f 7f1681817f7f0b81 bd
7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 46812e1e817f7fdb 0e
0000000000000000000000000000000000000000000000000000000000007f7f7f7f7f0000000000 d1160e3bc4af7f09 02
000000000000000000000000000000000000ce000000640000000000000000000000000000000000 09fbfb12ee12d600 00
00000000000000000000000000000000000000000000000000000000000000000000000000000000 0000000000000000 00
80808080807f7f7f7f7f80808080807f7f7f7f7f80808080807f7f7f7f7f80808080807f7f7f7f7f 7f1681817f7f0b81 bd
80808080808080808080808080808080808080808080808080808080808080808080808080808080 b97fd1e17f818125 0e
000000000000000000000000000000000000000000000000009c9c9c9c9c00000000000000000000 c200161721a6cc3a 00

// ==== tb/tb_conv3.sv ====
`timescale 1ns/1ps

module tb_conv3;
	import conv3_pkg::*;

	localparam int SHIFT           = 8;
	localparam int IN_DEPTH        = 4;
	localparam int OUT_CREDITS     = 2;
	localparam int NUM_VEC         = 24;                  // lines in the data file
	localparam int STREAM_VEC      = 16;                  // vectors sent while the sink keeps up
	localparam int HOLD_CYCLES     = 150;                 // long enough for the source to stall
	localparam int WATCHDOG_CYCLES = NUM_VEC * 20 + 500;

	logic      clk;
	logic      arst_n;
	logic      in_valid;
	in_vec_t   in_data;
	logic      in_credit;
	logic      out_valid;
	out_vec_t  out_data;
	sat_mask_t out_sat;
	logic      out_credit;

	logic [319:0] testdata [3*NUM_VEC];                   // vector, expected outputs, mask per line

	int    exp_q [$];                                     // file lines of the vectors in flight
	int    src_credits;                                   // input credits the source holds
	int    sent_count;
	int    credit_pulses;
	int    rx_count;
	int    rx_hold;                                       // beats seen while credits are held back
	int    owed;                                          // beats consumed but not yet credited
	int    errors;
	bit    first_sent;
	bit    hold_credits;
	string test_name;

	conv3_top #(
		.SHIFT       (SHIFT),
		.IN_DEPTH    (IN_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_sat    (out_sat),
		.out_credit (out_credit)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;                                 // 8 ns period

	// ****************************************
	// source side
	// ****************************************
	task automatic send_vectors(input int first, input int last);
		int idx;
		idx = first;
		while (idx <= last) begin
			@(posedge clk);
			#1;
			in_valid = 1'b0;
			if (src_credits > 0 && ($urandom % 4) != 0) begin   // a random idle gap now and then
				in_valid    = 1'b1;
				in_data     = testdata[3*idx];
				src_credits = src_credits - 1;
				exp_q.push_back(idx);
				sent_count  = sent_count + 1;
				first_sent  = 1'b1;
				idx         = idx + 1;
			end
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	// compares one output beat with the oldest vector in flight
	task automatic check_result();
		int          idx;
		logic [63:0] exp_data;
		logic [7:0]  exp_mask;
		if (exp_q.size() == 0) begin
			$display("%s: out_valid with no vector outstanding", test_name);
			errors = errors + 1;
		end else begin
			idx      = exp_q.pop_front();
			exp_data = testdata[3*idx+1][63:0];
			exp_mask = testdata[3*idx+2][7:0];
			if (out_data !== exp_data) begin
				$display("ERR %s vec %0d out_data: expected %h actual %h",
					test_name, idx, exp_data, out_data);
				errors = errors + 1;
			end
			if (out_sat !== exp_mask) begin
				$display("ERR %s vec %0d out_sat: expected %h actual %h",
					test_name, idx, exp_mask, out_sat);
				errors = errors + 1;
			end
		end
		rx_count = rx_count + 1;
		owed     = owed + 1;
		if (hold_credits) rx_hold = rx_hold + 1;
		if (owed > OUT_CREDITS) begin
			$display("%s: sink holds %0d results, more than its %0d slots", test_name, owed,
				OUT_CREDITS);
			errors = errors + 1;
		end
	endtask

	task automatic wait_results(input int target);
		while (rx_count < target) @(posedge clk);
	endtask

	task automatic wait_credits_returned();
		while (owed > 0) @(posedge clk);
	endtask

	// ****************************************
	// monitors sample on the falling edge
	// ****************************************
	always @(negedge clk) begin
		if (!first_sent && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
			$display("reset: out_valid or in_credit went high before any vector was sent");
			errors = errors + 1;
		end
		if (in_credit === 1'b1) begin
			credit_pulses = credit_pulses + 1;
			src_credits   = src_credits + 1;
			if (src_credits > IN_DEPTH) begin
				$display("%s: source was given more than %0d input credits", test_name,
					IN_DEPTH);
				errors = errors + 1;
			end
		end
		if (out_valid === 1'b1) check_result();
	end

	// the sink frees its slots a little later, unless it is told to hold them
	initial begin
		forever begin
			@(posedge clk);
			#1;
			out_credit = 1'b0;
			if (!hold_credits && owed > 0 && ($urandom % 3) != 0) begin
				out_credit = 1'b1;
				owed       = owed - 1;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	// ****************************************
	// test sequence
	// ****************************************
	initial begin
		void'($urandom(30));
		arst_n        = 1'b0;
		in_valid      = 1'b0;
		in_data       = '0;
		out_credit    = 1'b0;
		src_credits   = IN_DEPTH;                         // the buffer starts out empty
		sent_count    = 0;
		credit_pulses = 0;
		rx_count      = 0;
		rx_hold       = 0;
		owed          = 0;
		errors        = 0;
		first_sent    = 1'b0;
		hold_credits  = 1'b0;
		test_name     = "reset";
		$readmemh("tb/conv3_testdata.txt", testdata);
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_name = "stream";
		send_vectors(0, STREAM_VEC - 1);
		wait_results(STREAM_VEC);
		wait_credits_returned();

		test_name    = "backpressure";
		hold_credits = 1'b1;
		rx_hold      = 0;
		fork
			send_vectors(STREAM_VEC, NUM_VEC - 1);
			begin
				repeat (HOLD_CYCLES) @(posedge clk);
				if (rx_hold > OUT_CREDITS) begin
					$display("backpressure: %0d results arrived with only %0d credits",
						rx_hold, OUT_CREDITS);
					errors = errors + 1;
				end
				hold_credits = 1'b0;                      // the held slots go back from here on
			end
		join
		wait_results(NUM_VEC);
		wait_credits_returned();

		if (sent_count != NUM_VEC || exp_q.size() != 0) begin
			$display("end: %0d vectors sent and %0d still expected", sent_count, exp_q.size());
			errors = errors + 1;
		end
		if (credit_pulses != sent_count) begin
			$display("end: %0d in_credit pulses for %0d vectors sent", credit_pulses, sent_count);
			errors = errors + 1;
		end
		$display("tb_conv3: %0d results checked, %0d errors", rx_count, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
